// File: Makefile
# Verilator build and run of the PS/2 keyboard subsystem testbench
# any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= kbd_subsys_tb
FILELIST  ?= kbd_subsys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --assert

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP), look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	rm -f $(LOG)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "test ok"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/kbd_cr_regs.sv
`default_nettype none

`include "kbd_params.svh"

// memory-mapped data, status and ctrl registers for the core
module kbd_cr_regs (
    input  wire                  core_clk,
    input  wire                  reset,
    input  kbd_pkg::kbd_cr_req_t cr_req,
    output kbd_pkg::kbd_cr_rsp_t cr_rsp,
    input  kbd_pkg::kbd_scan_t   pop_data,
    input  wire                  empty,
    input  wire                  full,
    input  wire                  overrun_set,
    output logic                 pop,
    output logic                 scanf_en,
    output logic                 data_ready
);

    localparam int DW = kbd_pkg::KBD_DATA_W;
    localparam int PAD_W = DW - kbd_pkg::KBD_CODE_W - 2;

    logic          rd_data;     // read of the data register
    logic          wr_ctrl;     // write of the ctrl register
    logic          clr_sticky;
    logic          overrun_q;   // sticky, set by the controller
    logic          frame_err_q; // sticky, set when a bad entry is popped
    logic [DW-1:0] rdata_next;
    logic          rvalid_q;
    logic [DW-1:0] rdata_q;

    assign rd_data    = cr_req.rd && (cr_req.addr == `KBD_REG_DATA);
    assign wr_ctrl    = cr_req.wr && (cr_req.addr == `KBD_REG_CTRL);
    assign clr_sticky = wr_ctrl && cr_req.wdata[1];

    // pop in the request cycle, the response carries the old head
    assign pop        = rd_data && !empty;
    assign data_ready = !empty;

    always_comb begin
        rdata_next = '0; // unmapped offsets read zero
        case (cr_req.addr)
            `KBD_REG_DATA: begin
                if (!empty) begin
                    rdata_next = {{PAD_W{1'b0}}, 1'b1, pop_data.frame_err, pop_data.code};
                end
            end
            `KBD_REG_STATUS: rdata_next = {28'd0, frame_err_q, overrun_q, full, !empty};
            `KBD_REG_CTRL:   rdata_next = {31'd0, scanf_en}; // clear bit never reads back
            default:         rdata_next = '0;
        endcase
    end

    always_ff @(posedge core_clk) begin
        if (reset) begin
            scanf_en    <= 1'b0;
            overrun_q   <= 1'b0;
            frame_err_q <= 1'b0;
            rvalid_q    <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                scanf_en <= cr_req.wdata[0];
            end
            // a new event in the clearing cycle still sticks
            overrun_q   <= (overrun_q && !clr_sticky) || overrun_set;
            frame_err_q <= (frame_err_q && !clr_sticky) || (pop && pop_data.frame_err);
            rvalid_q    <= cr_req.rd;
        end
    end

    // read data only matters while rvalid is high
    always_ff @(posedge core_clk) begin
        if (cr_req.rd) begin
            rdata_q <= rdata_next;
        end
    end

    assign cr_rsp.rvalid = rvalid_q;
    assign cr_rsp.rdata  = rdata_q;

endmodule

`default_nettype wire

// File: hw/kbd_fifo.sv
`default_nettype none

// plain circular buffer with the head shown combinationally
module kbd_fifo #(
    parameter int  DEPTH   = 4,
    parameter type entry_t = logic [7:0]
) (
    input  wire    core_clk,
    input  wire    reset,
    input  wire    push,
    input  entry_t push_data,
    input  wire    pop,
    output entry_t pop_data,
    output logic   full,
    output logic   empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1); // wrap point
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    entry_t           mem [DEPTH]; // entry storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;       // entries currently held
    logic             do_push;
    logic             do_pop;

    // push while full and pop while empty are dropped here
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full     = (count == FULL_CNT);
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr]; // head entry while not empty

    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge core_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // both in one cycle leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/kbd_params.svh
`ifndef KBD_PARAMS_SVH
`define KBD_PARAMS_SVH

// receive fifo depth in scan-code entries
// small on purpose since the core polls the status register often
`define KBD_FIFO_DEPTH 4

// flop stages on kbd_clk and kbd_data before any logic looks at them
// two is the minimum for the edge detector in ps2_kbd_ctrl
`define KBD_SYNC_STAGES 2

// register offsets on the core port, 4-bit address
// data   bit 9 popped, bit 8 frame_err, bits 7:0 scan code
// status bit 3 frame err sticky, bit 2 overrun sticky, bit 1 full, bit 0 ready
// ctrl   bit 1 clear stickies (reads 0), bit 0 scanf_en
`define KBD_REG_DATA   4'h0
`define KBD_REG_STATUS 4'h4
`define KBD_REG_CTRL   4'h8

// any other offset reads back as zero

`endif

// File: hw/kbd_pkg.sv
`default_nettype none

package kbd_pkg;

    // one received byte as kept in the fifo
    typedef struct packed {
        logic [7:0] code;      // scan code, already in LSB-first order
        logic       frame_err; // start, stop or parity was wrong
    } kbd_scan_t;

    // request from the core, one cycle per access
    // rd and wr are never high together
    typedef struct packed {
        logic        rd;    // read strobe
        logic        wr;    // write strobe
        logic [3:0]  addr;  // byte offset of the register
        logic [31:0] wdata; // only ctrl uses the low two bits
    } kbd_cr_req_t;

    // registered read response
    // rvalid comes exactly one cycle after rd
    typedef struct packed {
        logic        rvalid; // single-cycle pulse
        logic [31:0] rdata;  // register contents, unused bits zero
    } kbd_cr_rsp_t;

    // sizes used by the register block when packing rdata
    localparam int KBD_CODE_W = 8;
    localparam int KBD_DATA_W = 32;

    // writes produce no response at all

endpackage

`default_nettype wire

// File: hw/kbd_subsys_top.sv
`default_nettype none

`include "kbd_params.svh"

// ps/2 receiver, scan-code fifo and core register port
module kbd_subsys_top (
    input  wire                  core_clk,
    input  wire                  reset,
    input  wire                  kbd_clk,
    input  wire                  kbd_data,
    input  kbd_pkg::kbd_cr_req_t cr_req,
    output kbd_pkg::kbd_cr_rsp_t cr_rsp,
    output logic                 data_ready
);

    logic               push;        // ctrl -> fifo
    kbd_pkg::kbd_scan_t push_data;
    logic               pop;         // regs -> fifo
    kbd_pkg::kbd_scan_t pop_data;
    logic               fifo_full;
    logic               fifo_empty;
    logic               overrun_set; // ctrl -> regs
    logic               scanf_en;    // regs -> ctrl

    ps2_kbd_ctrl ps2_kbd_ctrl_i (
        .core_clk    (core_clk),
        .reset       (reset),
        .kbd_clk     (kbd_clk),
        .kbd_data    (kbd_data),
        .scanf_en    (scanf_en),
        .fifo_full   (fifo_full),
        .push        (push),
        .push_data   (push_data),
        .overrun_set (overrun_set)
    );

    kbd_fifo #(
        .DEPTH   (`KBD_FIFO_DEPTH),
        .entry_t (kbd_pkg::kbd_scan_t)
    ) kbd_fifo_i (
        .core_clk  (core_clk),
        .reset     (reset),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    kbd_cr_regs kbd_cr_regs_i (
        .core_clk    (core_clk),
        .reset       (reset),
        .cr_req      (cr_req),
        .cr_rsp      (cr_rsp),
        .pop_data    (pop_data),
        .empty       (fifo_empty),
        .full        (fifo_full),
        .overrun_set (overrun_set),
        .pop         (pop),
        .scanf_en    (scanf_en),
        .data_ready  (data_ready)
    );

endmodule

`default_nettype wire

// File: hw/ps2_kbd_ctrl.sv
`default_nettype none

`include "kbd_params.svh"

// ps/2 receive side, everything sampled on core_clk
module ps2_kbd_ctrl (
    input  wire                core_clk,
    input  wire                reset,
    input  wire                kbd_clk,     // async, idles high
    input  wire                kbd_data,    // async, idles high
    input  wire                scanf_en,
    input  wire                fifo_full,
    output logic               push,
    output kbd_pkg::kbd_scan_t push_data,
    output logic               overrun_set
);

    localparam int SYNC_MSB = `KBD_SYNC_STAGES - 1;
    localparam logic [3:0] LAST_BIT = 4'd10; // stop bit position

    logic [SYNC_MSB:0] clk_sync;   // kbd_clk synchronizer chain
    logic [SYNC_MSB:0] data_sync;  // kbd_data synchronizer chain
    logic              clk_prev;   // last synchronized kbd_clk
    logic              clk_fall;
    logic [10:0]       shift_q;    // frame bits, first received ends at bit 0
    logic [10:0]       frame_next;
    logic [3:0]        bit_cnt;    // 0 means idle, waiting for start
    logic              frame_end;
    logic              start_ok;
    logic              stop_ok;
    logic              parity_ok;

    // both lines idle high so the chains reset to ones
    // otherwise the first cycle out of reset would look like a falling edge
    always_ff @(posedge core_clk) begin
        if (reset) begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[SYNC_MSB-1:0], kbd_clk};
            data_sync <= {data_sync[SYNC_MSB-1:0], kbd_data};
            clk_prev  <= clk_sync[SYNC_MSB];
        end
    end

    // keyboard drives data on the rising edge, we take it on the falling one
    assign clk_fall = clk_prev && !clk_sync[SYNC_MSB];

    // shift right so the data byte lands LSB first without reversal
    assign frame_next = {data_sync[SYNC_MSB], shift_q[10:1]};
    assign frame_end  = clk_fall && (bit_cnt == LAST_BIT);

    // frame checks, only meaningful when frame_end is high
    assign start_ok  = !frame_next[0];
    assign stop_ok   = frame_next[10];
    assign parity_ok = ^frame_next[9:1]; // odd over data plus parity

    always_ff @(posedge core_clk) begin
        if (clk_fall) begin
            shift_q <= frame_next;
        end
        if (frame_end) begin
            push_data.code      <= frame_next[8:1];
            push_data.frame_err <= !(start_ok && stop_ok && parity_ok);
        end
    end

    always_ff @(posedge core_clk) begin
        if (reset) begin
            bit_cnt     <= '0;
            push        <= 1'b0;
            overrun_set <= 1'b0;
        end else begin
            if (clk_fall) begin
                bit_cnt <= (bit_cnt == LAST_BIT) ? 4'd0 : bit_cnt + 4'd1;
            end
            // frames while disabled vanish without a trace
            push        <= frame_end && scanf_en && !fifo_full;
            overrun_set <= frame_end && scanf_en && fifo_full; // line can't stall
        end
    end

endmodule

`default_nettype wire

// File: kbd_subsys.f
+incdir+hw
hw/kbd_pkg.sv
hw/kbd_fifo.sv
hw/ps2_kbd_ctrl.sv
hw/kbd_cr_regs.sv
hw/kbd_subsys_top.sv
verification/kbd_subsys_tb.sv

// File: verification/kbd_subsys_tb.sv
`default_nettype none

`include "kbd_params.svh"

module kbd_subsys_tb;

    localparam int MAX_CYCLES = 20000; // whole run limit
    localparam int WAIT_LIMIT = 400;   // per wait in core cycles

    logic                 core_clk;
    logic                 reset;
    logic                 kbd_clk;
    logic                 kbd_data;
    kbd_pkg::kbd_cr_req_t cr_req;
    kbd_pkg::kbd_cr_rsp_t cr_rsp;
    logic                 data_ready;

    integer     seed;
    int         checks;
    int         errors;
    logic [9:0] exp_q[$];  // {popped, frame_err, code} per queued entry
    logic       en_model;  // expected scanf_en
    logic       ovr_model; // expected overrun sticky
    logic       ferr_model; // expected frame error sticky

    kbd_subsys_top dut_i (
        .core_clk   (core_clk),
        .reset      (reset),
        .kbd_clk    (kbd_clk),
        .kbd_data   (kbd_data),
        .cr_req     (cr_req),
        .cr_rsp     (cr_rsp),
        .data_ready (data_ready)
    );

    always #2 core_clk = ~core_clk; // period 4

    // response comes exactly one cycle after a read and at no other time
    assert property (@(posedge core_clk) disable iff (reset)
        cr_rsp.rvalid == $past(cr_req.rd))
    else begin
        errors++;
        $display("ERR t=%0t rvalid expected %0b got %0b", $time, !$sampled(cr_rsp.rvalid),
                 $sampled(cr_rsp.rvalid));
    end

    // all strobes quiet in the first cycle out of reset
    assert property (@(posedge core_clk) $fell(reset) |->
        !cr_rsp.rvalid && !data_ready && !dut_i.push && !dut_i.pop && !dut_i.overrun_set)
    else begin
        errors++;
        $display("ERR t=%0t rvalid/data_ready/push/pop/overrun_set expected 00000 got %b%b%b%b%b",
                 $time, $sampled(cr_rsp.rvalid), $sampled(data_ready), $sampled(dut_i.push),
                 $sampled(dut_i.pop), $sampled(dut_i.overrun_set));
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERR t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, got);
        end
    endtask

    // 11-bit frame with data changing while kbd_clk is high
    task automatic send_frame(input logic [7:0] code, input logic bad_parity,
                              input logic bad_stop);
        logic [10:0] bits;
        bits = {~bad_stop, (~^code) ^ bad_parity, code, 1'b0}; // stop, parity, data, start
        for (int i = 0; i < 11; i++) begin
            @(posedge core_clk);
            kbd_data <= bits[i];
            repeat (10) @(posedge core_clk);
            kbd_clk <= 1'b0; // controller samples here
            repeat (10) @(posedge core_clk);
            kbd_clk <= 1'b1;
        end
        @(posedge core_clk);
        kbd_data <= 1'b1; // back to idle
    endtask

    task automatic send_modeled(input logic [7:0] code, input logic bad_parity,
                                input logic bad_stop);
        send_frame(code, bad_parity, bad_stop);
        if (en_model) begin
            if (exp_q.size() < `KBD_FIFO_DEPTH)
                exp_q.push_back({1'b1, bad_parity | bad_stop, code});
            else
                ovr_model = 1'b1; // dropped since the line cannot stall
        end
    endtask

    task automatic read_reg(input logic [3:0] addr, output logic [31:0] data);
        int wait_cnt;
        wait_cnt = 0;
        @(posedge core_clk);
        cr_req <= '{rd: 1'b1, wr: 1'b0, addr: addr, wdata: 32'd0};
        @(posedge core_clk);
        cr_req <= '0;
        @(negedge core_clk); // sample mid-cycle
        while (!cr_rsp.rvalid && wait_cnt < WAIT_LIMIT) begin
            @(negedge core_clk);
            wait_cnt++;
        end
        if (!cr_rsp.rvalid) begin
            errors++;
            $display("no read response for offset 0x%h at t=%0t", addr, $time);
        end
        data = cr_rsp.rdata;
    endtask

    task automatic write_ctrl(input logic [31:0] wdata);
        @(posedge core_clk);
        cr_req <= '{rd: 1'b0, wr: 1'b1, addr: `KBD_REG_CTRL, wdata: wdata};
        @(posedge core_clk);
        cr_req <= '0;
        en_model = wdata[0];
        if (wdata[1]) begin
            ovr_model  = 1'b0;
            ferr_model = 1'b0;
        end
    endtask

    task automatic verify_status();
        logic [31:0] got;
        read_reg(`KBD_REG_STATUS, got);
        compare_value("status", got, {28'd0, ferr_model, ovr_model,
                      exp_q.size() == `KBD_FIFO_DEPTH, exp_q.size() != 0});
    endtask

    task automatic read_data_entry();
        logic [31:0] got;
        logic [31:0] exp;
        read_reg(`KBD_REG_DATA, got);
        exp = 32'd0; // empty read returns zero
        if (exp_q.size() > 0) begin
            exp = {22'd0, exp_q.pop_front()};
            ferr_model = ferr_model | exp[8];
        end
        compare_value("data", got, exp);
    endtask

    task automatic wait_for_ready();
        int wait_cnt;
        wait_cnt = 0;
        @(negedge core_clk);
        while (!data_ready && wait_cnt < WAIT_LIMIT) begin
            @(negedge core_clk);
            wait_cnt++;
        end
        if (!data_ready) begin
            errors++;
            $display("data_ready never rose at t=%0t", $time);
        end
    endtask

    task automatic hold_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge core_clk);
            compare_value("data_ready", {31'd0, data_ready}, 32'd0); // receiver disabled
        end
    endtask

    initial begin
        logic [31:0] got;
        seed       = 32'hcc35_8aed;
        core_clk   = 1'b0;
        reset      = 1'b1;
        kbd_clk    = 1'b1; // open-collector lines idle high
        kbd_data   = 1'b1;
        cr_req     = '0;
        checks     = 0;
        errors     = 0;
        en_model   = 1'b0;
        ovr_model  = 1'b0;
        ferr_model = 1'b0;
        repeat (4) @(posedge core_clk);
        reset <= 1'b0;

        // reset values
        @(negedge core_clk);
        compare_value("data_ready", {31'd0, data_ready}, 32'd0);
        verify_status();
        read_reg(`KBD_REG_CTRL, got);
        compare_value("ctrl", got, 32'd0);
        read_data_entry();

        // good frames in order
        write_ctrl(32'h1);
        for (int i = 0; i < 3; i++) begin
            send_modeled(8'($random(seed)), 1'b0, 1'b0);
            wait_for_ready();
        end
        verify_status();
        repeat (3) read_data_entry();
        @(negedge core_clk);
        compare_value("data_ready", {31'd0, data_ready}, 32'd0);

        // disabled receiver drops frames silently
        write_ctrl(32'h0);
        send_modeled(8'($random(seed)), 1'b0, 1'b0);
        hold_quiet(40);
        verify_status();

        // overflow loses the fifth frame
        write_ctrl(32'h1);
        repeat (5) send_modeled(8'($random(seed)), 1'b0, 1'b0);
        verify_status(); // full and overrun
        repeat (5) read_data_entry();

        // bad parity then bad stop
        send_modeled(8'($random(seed)), 1'b1, 1'b0);
        send_modeled(8'($random(seed)), 1'b0, 1'b1);
        wait_for_ready();
        repeat (2) read_data_entry();
        verify_status(); // both stickies set
        write_ctrl(32'h3); // clear stickies and stay enabled
        verify_status();
        read_reg(`KBD_REG_CTRL, got);
        compare_value("ctrl", got, 32'h1); // clear bit reads 0

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // whole-run guard
    initial begin
        repeat (MAX_CYCLES) @(posedge core_clk);
        $display("run did not finish within %0d cycles", MAX_CYCLES);
        $display("checks %0d errors %0d", checks, errors + 1);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire
